// ==== all.f ====
source/ndn_link_pkg.sv
source/ndn_frame_rx.sv
source/ndn_frame_tx.sv
source/ndn_link_top.sv
tests/ndn_link_checker.sv
tests/tb_ndn_link.sv

// ==== Bender.yml ====
package:
  name: ndn_link

sources:
  - source/ndn_link_pkg.sv
  - source/ndn_frame_rx.sv
  - source/ndn_frame_tx.sv
  - source/ndn_link_top.sv
  - target: test
    files:
      - tests/ndn_link_checker.sv
      - tests/tb_ndn_link.sv

// ==== tests/tb_ndn_link.sv ====
// NDN link testbench
`timescale 1ns/10ps

module tb_ndn_link import ndn_link_pkg::*;;

    localparam int PAYLOAD_BYTES = 4;
    // Longest frame is about 110 cycles
    localparam int WAIT_LIMIT = 400;
    localparam int TX_PACKETS = 24;
    localparam int LINE_FRAMES = 24;

    logic       clk;
    logic       rst;
    logic       miso;
    logic [7:0] tx_byte;
    logic       tx_valid;
    logic       tx_first;
    logic       mosi;
    logic       tx_busy;
    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       rx_first;
    logic       rx_frame_error;

    integer seed;
    integer timeouts;
    // Serial bits waiting to go onto miso
    logic   line_bits[$];

    ndn_link_top #(
        .PAYLOAD_BYTES (PAYLOAD_BYTES)
    ) UUT (
        .clk            (clk),
        .rst            (rst),
        .miso           (miso),
        .mosi           (mosi),
        .tx_byte        (tx_byte),
        .tx_valid       (tx_valid),
        .tx_first       (tx_first),
        .tx_busy        (tx_busy),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .rx_first       (rx_first),
        .rx_frame_error (rx_frame_error)
    );

    ndn_link_checker #(
        .PAYLOAD_BYTES (PAYLOAD_BYTES)
    ) chk (
        .clk            (clk),
        .rst            (rst),
        .mosi           (mosi),
        .tx_busy        (tx_busy),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .rx_first       (rx_first),
        .rx_frame_error (rx_frame_error)
    );

    always #5 clk = ~clk;

    task automatic push_line_byte(input logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            line_bits.push_back(b[i]);
        end
    endtask

    // Random miso frame, one in five with a high end bit
    task automatic build_line_frame();
        logic [7:0] b;
        logic       bad;
        int         nbytes;
        bad = ({$random(seed)} % 5) == 0;
        b = $random(seed);
        nbytes = b[TYPE_BIT] ? 1 + PREFIX_BYTES : 1 + PREFIX_BYTES + PAYLOAD_BYTES;
        line_bits.push_back(1'b0);
        for (int k = 0; k < nbytes; k++) begin
            if (k > 0) b = $random(seed);
            push_line_byte(b);
            if (!bad) chk.expect_rx(k == 0, b);
        end
        line_bits.push_back(bad);
        if (bad) chk.expect_frame_error();
        // High gap longer than the unload
        repeat (1 + PREFIX_BYTES + PAYLOAD_BYTES + 3 + {$random(seed)} % 8) begin
            line_bits.push_back(1'b1);
        end
    endtask

    task automatic drive_line();
        while (line_bits.size() > 0) begin
            @(negedge clk);
            miso = line_bits.pop_front();
        end
    endtask

    // Wait for tx_busy low, strobing junk bytes while the frame goes out
    task automatic wait_tx_idle();
        logic [31:0] r;
        int          n;
        n = 0;
        @(negedge clk);
        while (tx_busy && n < WAIT_LIMIT) begin
            r = $random(seed);
            tx_valid = r[0];
            tx_first = r[1];
            tx_byte  = r[15:8];
            @(negedge clk);
            n++;
        end
        tx_valid = 1'b0;
        tx_first = 1'b0;
        if (tx_busy) begin
            timeouts++;
            $display("Timeout at %0t: tx_busy stayed high after a packet", $time);
        end
    endtask

    // One FIB packet with random gaps between strobes
    task automatic send_packet();
        logic [7:0] b;
        int         nbytes;
        b = $random(seed);
        nbytes = b[TYPE_BIT] ? 1 + PREFIX_BYTES : 1 + PREFIX_BYTES + PAYLOAD_BYTES;
        for (int k = 0; k < nbytes; k++) begin
            if (k > 0) b = $random(seed);
            repeat ({$random(seed)} % 3) begin
                @(negedge clk);
                tx_valid = 1'b0;
            end
            @(negedge clk);
            tx_valid = 1'b1;
            tx_first = (k == 0);
            tx_byte  = b;
            chk.expect_tx(b);
        end
        wait_tx_idle();
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (!chk.drained() && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!chk.drained()) begin
            timeouts++;
            $display("Timeout at %0t: expected traffic never showed up", $time);
        end
    endtask

    initial begin
        seed = 7;
        timeouts = 0;
        clk = 1'b0;
        rst = 1'b1;
        miso = 1'b1;
        tx_byte = 8'h00;
        tx_valid = 1'b0;
        tx_first = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        chk.check_reset_values();
        // Whole miso stream first, then the FIB stream draws from the seed
        for (int i = 0; i < LINE_FRAMES; i++) begin
            build_line_frame();
        end
        fork
            drive_line();
            for (int i = 0; i < TX_PACKETS; i++) begin
                send_packet();
            end
        join
        wait_drained();
        chk.final_check();
        $display("Error counts: mosi %0d, rx %0d, timeouts %0d",
                 chk.tx_errors, chk.rx_errors, timeouts);
        if (chk.tx_errors + chk.rx_errors + timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/ndn_link_checker.sv ====
// NDN link checker
`timescale 1ns/10ps

module ndn_link_checker import ndn_link_pkg::*; #(
    parameter int PAYLOAD_BYTES = 32
) (
    input logic       clk,
    input logic       rst,
    input logic       mosi,
    input logic       tx_busy,
    input logic [7:0] rx_byte,
    input logic       rx_valid,
    input logic       rx_first,
    input logic       rx_frame_error
);

    integer tx_errors = 0;
    integer rx_errors = 0;

    // Expected traffic filled by the testbench
    logic [7:0] tx_exp_q[$];
    logic [8:0] rx_exp_q[$];
    integer     err_expected = 0;
    integer     err_seen = 0;

    // mosi frame decoder
    logic       in_frame = 1'b0;
    logic       frame_done = 1'b0;
    int         bit_idx;
    int         frame_bits;
    logic [7:0] shift;
    logic [7:0] tx_exp;
    logic [8:0] rx_exp;

    task automatic expect_tx(input logic [7:0] b);
        tx_exp_q.push_back(b);
    endtask

    // Bit 8 flags the metadata byte
    task automatic expect_rx(input logic first, input logic [7:0] b);
        rx_exp_q.push_back({first, b});
    endtask

    task automatic expect_frame_error();
        err_expected++;
    endtask

    // Idle line check after the last frame must also have run
    function automatic bit drained();
        return (tx_exp_q.size() == 0) && (rx_exp_q.size() == 0) && !in_frame && !frame_done;
    endfunction

    task automatic value_error(input string name, input logic [31:0] expv,
                               input logic [31:0] actv, input bit rx_side);
        $display("Fail at %0t: %s expected %0h, got %0h", $time, name, expv, actv);
        if (rx_side) begin
            rx_errors++;
        end else begin
            tx_errors++;
        end
    endtask

    // Idle outputs before any stimulus
    task automatic check_reset_values();
        if (mosi !== 1'b1) value_error("mosi", 1, mosi, 0);
        if (tx_busy !== 1'b0) value_error("tx_busy", 0, tx_busy, 0);
        if (rx_valid !== 1'b0) value_error("rx_valid", 0, rx_valid, 1);
        if (rx_first !== 1'b0) value_error("rx_first", 0, rx_first, 1);
        if (rx_frame_error !== 1'b0) value_error("rx_frame_error", 0, rx_frame_error, 1);
    endtask

    task automatic final_check();
        if (err_seen != err_expected) begin
            value_error("rx_frame_error pulse count", err_expected, err_seen, 1);
        end
        if (tx_exp_q.size() != 0) begin
            $display("%0d packet bytes never appeared on mosi", tx_exp_q.size());
            tx_errors++;
        end
        if (rx_exp_q.size() != 0) begin
            $display("%0d line bytes never came out on rx_byte", rx_exp_q.size());
            rx_errors++;
        end
    endtask

    // Decode mosi frames one bit per clock
    always @(posedge clk) begin
        if (!rst) begin
            if (frame_done) begin
                // Line idle again and busy released together
                frame_done = 1'b0;
                if (mosi !== 1'b1) value_error("mosi", 1, mosi, 0);
                if (tx_busy !== 1'b0) value_error("tx_busy", 0, tx_busy, 0);
            end else if (!in_frame) begin
                if (mosi === 1'b0) begin
                    // Start bit assumes interest length until the type bit says otherwise
                    in_frame = 1'b1;
                    bit_idx = 0;
                    frame_bits = 8 * (1 + PREFIX_BYTES);
                    if (tx_busy !== 1'b1) value_error("tx_busy", 1, tx_busy, 0);
                end
            end else begin
                if (tx_busy !== 1'b1) value_error("tx_busy", 1, tx_busy, 0);
                if (bit_idx < frame_bits) begin
                    shift = {shift[6:0], mosi};
                    bit_idx++;
                    // Low type bit means a data packet with payload
                    if (bit_idx == 8 - TYPE_BIT && mosi === 1'b0) begin
                        frame_bits = 8 * (1 + PREFIX_BYTES + PAYLOAD_BYTES);
                    end
                    if (bit_idx % 8 == 0) begin
                        if (tx_exp_q.size() == 0) begin
                            $display("At %0t mosi carried byte %0h that was never sent",
                                     $time, shift);
                            tx_errors++;
                        end else begin
                            tx_exp = tx_exp_q.pop_front();
                            if (shift !== tx_exp) value_error("mosi byte", tx_exp, shift, 0);
                        end
                    end
                end else begin
                    if (mosi !== 1'b0) value_error("mosi end bit", 0, mosi, 0);
                    in_frame = 1'b0;
                    frame_done = 1'b1;
                end
            end
        end
    end

    // Bytes handed to the FIB side
    always @(posedge clk) begin
        if (!rst) begin
            if (rx_frame_error === 1'b1) err_seen++;
            if (rx_first === 1'b1 && rx_valid !== 1'b1) value_error("rx_valid", 1, rx_valid, 1);
            if (rx_valid === 1'b1) begin
                if (rx_exp_q.size() == 0) begin
                    $display("At %0t rx_valid delivered byte %0h with no good frame pending",
                             $time, rx_byte);
                    rx_errors++;
                end else begin
                    rx_exp = rx_exp_q.pop_front();
                    if (rx_byte !== rx_exp[7:0]) value_error("rx_byte", rx_exp[7:0], rx_byte, 1);
                    if (rx_first !== rx_exp[8]) value_error("rx_first", rx_exp[8], rx_first, 1);
                end
            end
        end
    end

endmodule

// ==== source/ndn_link_top.sv ====
// NDN serial link top
`timescale 1ns/10ps

module ndn_link_top #(
    parameter int PAYLOAD_BYTES = 32
) (
    input  logic       clk,
    input  logic       rst,
    // Serial line
    input  logic       miso,
    output logic       mosi,
    // FIB side, outgoing packets
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    input  logic       tx_first,
    output logic       tx_busy,
    // FIB side, incoming packets
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       rx_first,
    output logic       rx_frame_error
);

    // Line to FIB
    ndn_frame_rx #(
        .PAYLOAD_BYTES (PAYLOAD_BYTES)
    ) u_rx (
        .clk            (clk),
        .rst            (rst),
        .miso           (miso),
        .rx_byte        (rx_byte),
        .rx_valid       (rx_valid),
        .rx_first       (rx_first),
        .rx_frame_error (rx_frame_error)
    );

    // FIB to line
    ndn_frame_tx #(
        .PAYLOAD_BYTES (PAYLOAD_BYTES)
    ) u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_first (tx_first),
        .mosi     (mosi),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== source/ndn_frame_tx.sv ====
// NDN frame transmitter
`timescale 1ns/10ps

module ndn_frame_tx import ndn_link_pkg::*; #(
    parameter int PAYLOAD_BYTES = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] tx_byte,
    input  logic       tx_valid,
    input  logic       tx_first,
    output logic       mosi,
    output logic       tx_busy
);

    localparam int TOTAL_BYTES = 1 + PREFIX_BYTES + PAYLOAD_BYTES;
    localparam int STORE_BITS = 8 * TOTAL_BYTES;
    localparam int BYTE_CNT_W = $clog2(TOTAL_BYTES);
    localparam int BIT_CNT_W = $clog2(STORE_BITS + 1);

    tx_state_t state;

    logic                  pkt_open;
    logic                  data_pkt;
    logic                  take_byte;
    logic [BYTE_CNT_W-1:0] byte_cnt;
    logic [BYTE_CNT_W-1:0] wr_idx;
    logic [BYTE_CNT_W-1:0] last_idx;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    logic [BIT_CNT_W-1:0]  frame_bits;

    // Packet bytes, metadata in the top byte
    logic [STORE_BITS-1:0] store;

    // Metadata always starts a packet, other bytes need an open one
    assign take_byte = (state == TX_COLLECT) && tx_valid && (tx_first || pkt_open);
    assign wr_idx = tx_first ? '0 : byte_cnt;

    // Packet size follows the latched type
    assign last_idx = data_pkt ? BYTE_CNT_W'(TOTAL_BYTES - 1) : BYTE_CNT_W'(PREFIX_BYTES);
    assign frame_bits = data_pkt ? BIT_CNT_W'(STORE_BITS)
                                 : BIT_CNT_W'(8 * (1 + PREFIX_BYTES));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_COLLECT;
            pkt_open <= 1'b0;
            data_pkt <= 1'b0;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            mosi     <= 1'b1;
            tx_busy  <= 1'b0;
        end else begin
            case (state)
                TX_COLLECT: begin
                    if (tx_valid && tx_first) begin
                        // New packet, or restart of an open one
                        pkt_open <= 1'b1;
                        tx_busy  <= 1'b1;
                        data_pkt <= (pkt_type_t'(tx_byte[TYPE_BIT]) == PKT_DATA);
                        byte_cnt <= BYTE_CNT_W'(1);
                    end else if (tx_valid && pkt_open) begin
                        if (byte_cnt == last_idx) begin
                            // Last byte taken, start bit next cycle
                            pkt_open <= 1'b0;
                            mosi     <= 1'b0;
                            state    <= TX_START;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                TX_START: begin
                    mosi    <= store[STORE_BITS-1];
                    bit_cnt <= BIT_CNT_W'(1);
                    state   <= TX_SHIFT;
                end
                TX_SHIFT: begin
                    if (bit_cnt == frame_bits) begin
                        // Low end bit
                        mosi  <= 1'b0;
                        state <= TX_END;
                    end else begin
                        mosi    <= store[STORE_BITS-1];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                TX_END: begin
                    // Line back to idle high
                    mosi    <= 1'b1;
                    tx_busy <= 1'b0;
                    state   <= TX_COLLECT;
                end
                default: state <= TX_COLLECT;
            endcase
        end
    end

    // Bytes land by index so both packet types sit MSB aligned
    always_ff @(posedge clk) begin
        if (take_byte) begin
            store[(TOTAL_BYTES - 1 - wr_idx) * 8 +: 8] <= tx_byte;
        end else if (state == TX_START || state == TX_SHIFT) begin
            store <= store << 1;
        end
    end

    // Line stays idle while bytes are collected
    a_idle_high: assert property (
        @(posedge clk) disable iff (rst) (state == TX_COLLECT) |-> mosi
    );

    a_busy_open: assert property (
        @(posedge clk) disable iff (rst) (state == TX_COLLECT && !pkt_open) |-> !tx_busy
    );

endmodule

// ==== source/ndn_frame_rx.sv ====
// NDN frame receiver
`timescale 1ns/10ps

module ndn_frame_rx import ndn_link_pkg::*; #(
    parameter int PAYLOAD_BYTES = 32
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       miso,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       rx_first,
    output logic       rx_frame_error
);

    localparam int PAYLOAD_BITS = 8 * PAYLOAD_BYTES;
    // Longest field decides the bit counter width
    localparam int MAX_BITS = (PAYLOAD_BITS > PREFIX_BITS) ? PAYLOAD_BITS : PREFIX_BITS;
    localparam int BIT_CNT_W = $clog2(MAX_BITS);
    localparam int TOTAL_BYTES = 1 + PREFIX_BYTES + PAYLOAD_BYTES;
    localparam int BYTE_CNT_W = $clog2(TOTAL_BYTES + 1);

    rx_state_t state;
    pkt_type_t rx_type;

    logic [BIT_CNT_W-1:0]    bit_cnt;
    logic [BYTE_CNT_W-1:0]   byte_cnt;
    logic [BYTE_CNT_W-1:0]   last_cnt;
    logic                    unload_done;
    logic                    unload_step;

    // Field registers, filled MSB first
    logic [META_BITS-1:0]    meta;
    logic [PREFIX_BITS-1:0]  prefix;
    logic [PAYLOAD_BITS-1:0] payload;

    // Bytes to hand over for this packet
    assign last_cnt = (rx_type == PKT_INTEREST) ? BYTE_CNT_W'(1 + PREFIX_BYTES)
                                                : BYTE_CNT_W'(TOTAL_BYTES);
    assign unload_done = (byte_cnt == last_cnt);
    assign unload_step = (state == RX_UNLOAD) && !unload_done;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state          <= RX_IDLE;
            rx_type        <= PKT_DATA;
            bit_cnt        <= '0;
            byte_cnt       <= '0;
            rx_valid       <= 1'b0;
            rx_first       <= 1'b0;
            rx_frame_error <= 1'b0;
        end else begin
            // Error flag is a single-cycle pulse
            rx_frame_error <= 1'b0;
            case (state)
                RX_IDLE: begin
                    // Low sample on an idle line is the start bit
                    if (!miso) begin
                        bit_cnt <= '0;
                        state   <= RX_META;
                    end
                end
                RX_META: begin
                    // Type bit decides whether a payload follows
                    if (bit_cnt == BIT_CNT_W'(META_BITS - 1 - TYPE_BIT)) begin
                        rx_type <= pkt_type_t'(miso);
                    end
                    if (bit_cnt == BIT_CNT_W'(META_BITS - 1)) begin
                        bit_cnt <= '0;
                        state   <= RX_PREFIX;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_PREFIX: begin
                    if (bit_cnt == BIT_CNT_W'(PREFIX_BITS - 1)) begin
                        bit_cnt <= '0;
                        state   <= (rx_type == PKT_INTEREST) ? RX_END : RX_PAYLOAD;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_PAYLOAD: begin
                    if (bit_cnt == BIT_CNT_W'(PAYLOAD_BITS - 1)) begin
                        bit_cnt <= '0;
                        state   <= RX_END;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                RX_END: begin
                    if (!miso) begin
                        // Good end bit, metadata byte goes out first
                        rx_valid <= 1'b1;
                        rx_first <= 1'b1;
                        byte_cnt <= BYTE_CNT_W'(1);
                        state    <= RX_UNLOAD;
                    end else begin
                        rx_frame_error <= 1'b1;
                        state          <= RX_IDLE;
                    end
                end
                RX_UNLOAD: begin
                    rx_first <= 1'b0;
                    if (unload_done) begin
                        rx_valid <= 1'b0;
                        state    <= RX_IDLE;
                    end else begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // Shift registers and unload chain
    always_ff @(posedge clk) begin
        case (state)
            RX_META:    meta <= {meta[META_BITS-2:0], miso};
            RX_PREFIX:  prefix <= {prefix[PREFIX_BITS-2:0], miso};
            RX_PAYLOAD: payload <= {payload[PAYLOAD_BITS-2:0], miso};
            RX_END:     rx_byte <= meta;
            default: ;
        endcase
        // Prefix and payload drain as one byte chain
        if (unload_step) begin
            rx_byte <= prefix[PREFIX_BITS-1 -: 8];
            prefix  <= {prefix[PREFIX_BITS-9:0], payload[PAYLOAD_BITS-1 -: 8]};
            payload <= payload << 8;
        end
    end

    // Byte strobes only while unloading
    a_valid_unload: assert property (
        @(posedge clk) disable iff (rst) rx_valid |-> (state == RX_UNLOAD)
    );

    a_first_valid: assert property (
        @(posedge clk) disable iff (rst) rx_first |-> rx_valid
    );

endmodule

// ==== source/ndn_link_pkg.sv ====
// NDN link frame definitions

package ndn_link_pkg;

    // Metadata field: don't care, packet type, prefix length
    localparam int META_BITS = 8;

    // Prefix field, sent MSB first
    localparam int PREFIX_BITS = 64;
    localparam int PREFIX_BYTES = PREFIX_BITS / 8;

    // Packet type position inside the metadata byte
    localparam int TYPE_BIT = 6;

    // Value of the type bit
    typedef enum logic {
        PKT_DATA     = 1'b0,
        PKT_INTEREST = 1'b1
    } pkt_type_t;

    // Receiver FSM
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_META,
        RX_PREFIX,
        RX_PAYLOAD,
        RX_END,
        RX_UNLOAD
    } rx_state_t;

    // Transmitter FSM
    typedef enum logic [1:0] {
        TX_COLLECT,
        TX_START,
        TX_SHIFT,
        TX_END
    } tx_state_t;

endpackage
